//--- sim.f
+incdir+hdl
hdl/riscboy_pkg.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/apb_bridge.sv
hdl/gpio_regs.sv
hdl/riscboy_fabric.sv
testbench/fabric_checker.sv
testbench/tb_riscboy.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_riscboy
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_riscboy.sv
/* Testbench for the bus fabric, acting as both masters.
   Stimulus comes from a fixed-seed xorshift; fabric_checker does the comparing. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module tb_riscboy;

localparam int N_TRANS   = 170;               // Sum over all six tests
localparam int WD_CYCLES = N_TRANS * 20 + 3;

logic                  clk;
logic                  rst_n;
logic                  proc_req_valid;
logic                  ppu_req_valid;
riscboy_pkg::bus_req_t proc_req;
riscboy_pkg::bus_req_t ppu_req;
logic                  proc_req_ready;
logic                  ppu_req_ready;
logic                  proc_rsp_valid;
logic                  ppu_rsp_valid;
riscboy_pkg::bus_rsp_t proc_rsp;
riscboy_pkg::bus_rsp_t ppu_rsp;
logic                  proc_rsp_ready;
logic                  ppu_rsp_ready;
riscboy_pkg::pads_t    padout;
riscboy_pkg::pads_t    padoe;
riscboy_pkg::pads_t    padin;
logic                  backpressure;
logic [31:0]           rng;
logic [31:0]           bp_rand;
logic [31:0]           pin_rand;
int                    err_base;
int                    n_fail_tests;

riscboy_fabric DUT (.*);
fabric_checker mon (.*);

always #2 clk = ~clk;

function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x   = rng;
	x   = x ^ (x << 13);
	x   = x ^ (x >> 17);
	x   = x ^ (x << 5);
	rng = x;
	return x;
endfunction

function automatic riscboy_pkg::bus_req_t make_req(input riscboy_pkg::addr_t addr,
		input logic write, input riscboy_pkg::data_t wdata, input riscboy_pkg::strb_t strb);
	riscboy_pkg::bus_req_t r;
	r.addr  = addr;
	r.write = write;
	r.wdata = wdata;
	r.wstrb = strb;
	return r;
endfunction

// Random alias bits above the array exercise the partial decode
function automatic riscboy_pkg::addr_t sram_addr(input int idx);
	return `RB_SRAM_BASE | ((next_rand() & 32'h3f) << 13) | (riscboy_pkg::addr_t'(idx) << 2);
endfunction

function automatic riscboy_pkg::addr_t gpio_addr(input riscboy_pkg::paddr_t ofs);
	return `RB_APB_BASE | riscboy_pkg::addr_t'(`RB_GPIO_SLOT | ofs);
endfunction

task automatic drive_req(input bit is_ppu, input logic valid, input riscboy_pkg::bus_req_t req);
	if (is_ppu) begin
		ppu_req_valid = valid;
		ppu_req       = req;
	end else begin
		proc_req_valid = valid;
		proc_req       = req;
	end
endtask

// One request and its response; handshakes are sampled mid-cycle
task automatic transact(input bit is_ppu, input riscboy_pkg::bus_req_t req);
	bit done;
	@(negedge clk);
	drive_req(is_ppu, 1'b1, req);
	done = 1'b0;
	while (!done) begin
		#1;
		done = is_ppu ? ppu_req_ready : proc_req_ready;
		@(negedge clk);
	end
	drive_req(is_ppu, 1'b0, '0);
	done = 1'b0;
	while (!done) begin
		#1;
		done = is_ppu ? (ppu_rsp_valid && ppu_rsp_ready) : (proc_rsp_valid && proc_rsp_ready);
		@(negedge clk);
	end
endtask

task automatic sram_traffic(input bit is_ppu, input int n);
	logic [31:0] r;
	for (int i = 0; i < n; i++) begin
		repeat (next_rand() % 3) @(negedge clk);
		r = next_rand();
		transact(is_ppu, make_req(sram_addr(int'(r[8:4])), r[0], next_rand(), r[3:0]));
	end
endtask

task automatic mixed_traffic(input bit is_ppu, input int n);
	logic [31:0] r;
	for (int i = 0; i < n; i++) begin
		repeat (next_rand() % 3) @(negedge clk);
		r = next_rand();
		if (r[0])
			transact(is_ppu, make_req(sram_addr(int'(r[8:4])), r[1], next_rand(), r[3:0]));
		else
			transact(is_ppu, make_req(gpio_addr(r[2] ? `RB_GPIO_OE_OFS : `RB_GPIO_OUT_OFS),
				r[1], next_rand(), 4'hf));
	end
endtask

task automatic end_test(input int num, input string name);
	int n;
	n = mon.errors - err_base;
	if (n != 0)
		n_fail_tests++;
	$display("Test %0d %s: %s (%0d errors)", num, name, n == 0 ? "ok" : "FAILED", n);
	err_base = mon.errors;
endtask

// Response back-pressure for test 6
always @(negedge clk) begin
	if (backpressure) begin
		bp_rand        = next_rand();
		proc_rsp_ready = bp_rand[0];
		ppu_rsp_ready  = bp_rand[1];
	end else begin
		proc_rsp_ready = 1'b1;
		ppu_rsp_ready  = 1'b1;
	end
end

initial begin
	repeat (WD_CYCLES) @(posedge clk);
	$display("Watchdog expired before the tests finished");
	$display("Simulation failed");
	$finish;
end

// ====================
// Test sequence

initial begin
	clk            = 1'b0;
	rst_n          = 1'b0;
	proc_req_valid = 1'b0;
	ppu_req_valid  = 1'b0;
	proc_req       = '0;
	ppu_req        = '0;
	proc_rsp_ready = 1'b1;
	ppu_rsp_ready  = 1'b1;
	padin          = '0;
	backpressure   = 1'b0;
	rng            = 32'd76964;
	err_base       = 0;
	n_fail_tests   = 0;
	repeat (3) @(negedge clk);
	rst_n = 1'b1;

	for (int i = 0; i < 16; i++)
		transact(1'b0, make_req(sram_addr(i), 1'b1, next_rand(), 4'hf));
	for (int i = 0; i < 24; i++) begin
		bp_rand = next_rand();
		transact(1'b0, make_req(sram_addr(int'(bp_rand[7:4])), 1'b1, next_rand(), bp_rand[3:0]));
	end
	for (int i = 0; i < 16; i++)
		transact(1'b0, make_req(sram_addr(i), 1'b0, '0, '0));
	end_test(1, "sram strobe writes");

	fork
		sram_traffic(1'b1, 24);
		sram_traffic(1'b0, 24);
	join
	end_test(2, "two master sram traffic");

	for (int i = 0; i < 4; i++) begin
		transact(1'b0, make_req(gpio_addr(`RB_GPIO_OUT_OFS), 1'b1, next_rand(), 4'hf));
		transact(1'b1, make_req(gpio_addr(`RB_GPIO_OE_OFS), 1'b1, next_rand(), 4'hf));
		transact(1'b0, make_req(gpio_addr(`RB_GPIO_OUT_OFS), 1'b0, '0, '0));
		transact(1'b1, make_req(gpio_addr(`RB_GPIO_OE_OFS), 1'b0, '0, '0));
	end
	end_test(3, "gpio out and oe");

	for (int i = 0; i < 4; i++) begin
		@(negedge clk);
		pin_rand = next_rand();
		padin    = pin_rand[`RB_N_PADS-1:0];
		repeat (2) @(negedge clk);           // Let the synchronizer settle
		transact(1'b0, make_req(gpio_addr(`RB_GPIO_IN_OFS), 1'b0, '0, '0));
	end
	end_test(4, "gpio pad input");

	transact(1'b0, make_req(32'h6000_0000 | (next_rand() & 32'h1fff_fffc), 1'b0, '0, '0));
	transact(1'b1, make_req(`RB_SRAM_BASE | 32'h0008_0000, 1'b0, '0, '0));
	transact(1'b0, make_req(`RB_APB_BASE | 32'h0000_3000, 1'b1, next_rand(), 4'hf));
	transact(1'b1, make_req(gpio_addr(16'h000c), 1'b0, '0, '0));
	transact(1'b0, make_req(gpio_addr(`RB_GPIO_IN_OFS), 1'b1, next_rand(), 4'hf));
	transact(1'b1, make_req(gpio_addr(16'h0010), 1'b1, next_rand(), 4'hf));
	end_test(5, "error responses");

	backpressure = 1'b1;
	fork
		mixed_traffic(1'b1, 20);
		mixed_traffic(1'b0, 20);
	join
	backpressure = 1'b0;
	end_test(6, "response back-pressure");

	$display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
		n_fail_tests, mon.checks, mon.errors);
	if (mon.errors == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

//--- testbench/fabric_checker.sv
/* Scoreboard for the fabric. Each response is predicted when its request
   is accepted, which holds because only one transaction is in flight.
   SRAM bytes that were never written are not compared. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module fabric_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  proc_req_valid,
	input logic                  ppu_req_valid,
	input riscboy_pkg::bus_req_t proc_req,
	input riscboy_pkg::bus_req_t ppu_req,
	input logic                  proc_req_ready,
	input logic                  ppu_req_ready,
	input logic                  proc_rsp_valid,
	input logic                  ppu_rsp_valid,
	input riscboy_pkg::bus_rsp_t proc_rsp,
	input riscboy_pkg::bus_rsp_t ppu_rsp,
	input logic                  proc_rsp_ready,
	input logic                  ppu_rsp_ready,
	input riscboy_pkg::pads_t    padout,
	input riscboy_pkg::pads_t    padoe,
	input riscboy_pkg::pads_t    padin
);

typedef struct packed {
	riscboy_pkg::data_t rdata;
	riscboy_pkg::data_t mask;    // Bits of rdata to compare
	logic               err;
} expect_t;

localparam int N_WORDS = 1 << `RB_SRAM_DEPTH_LOG2;

riscboy_pkg::data_t mem   [N_WORDS];
riscboy_pkg::strb_t known [N_WORDS];    // Bytes written so far
riscboy_pkg::pads_t out_m;
riscboy_pkg::pads_t oe_m;
expect_t            proc_q [$];
expect_t            ppu_q  [$];
int                 errors;
int                 checks;

initial begin
	errors = 0;
	checks = 0;
	out_m  = '0;
	oe_m   = '0;
	for (int i = 0; i < N_WORDS; i++) begin
		mem[i]   = '0;
		known[i] = '0;
	end
end

function automatic riscboy_pkg::data_t strb_to_bits(input riscboy_pkg::strb_t s);
	riscboy_pkg::data_t m;
	for (int b = 0; b < 4; b++)
		m[b*8 +: 8] = {8{s[b]}};
	return m;
endfunction

// ====================
// Reference model

function automatic expect_t apply_request(input riscboy_pkg::bus_req_t req);
	expect_t             e;
	riscboy_pkg::paddr_t ofs;
	int                  idx;
	e.rdata = '0;
	e.mask  = '1;
	e.err   = 1'b0;
	ofs     = req.addr[`RB_W_PADDR-1:0] & ~`RB_APB_SLOT_MASK;
	if ((req.addr & `RB_SRAM_MASK) == `RB_SRAM_BASE) begin
		idx     = int'(req.addr[`RB_SRAM_DEPTH_LOG2+1:2]);
		e.rdata = mem[idx];
		e.mask  = req.write ? '0 : strb_to_bits(known[idx]);
		for (int b = 0; b < 4; b++) begin
			if (req.write && req.wstrb[b]) begin
				mem[idx][b*8 +: 8] = req.wdata[b*8 +: 8];
				known[idx][b]      = 1'b1;
			end
		end
	end else if ((req.addr & `RB_APB_MASK) != `RB_APB_BASE) begin
		e.err = 1'b1;                        // Outside both windows
	end else if ((req.addr[`RB_W_PADDR-1:0] & `RB_APB_SLOT_MASK) != `RB_GPIO_SLOT) begin
		e.err = 1'b1;                        // Unmapped slot, zero data
	end else begin
		if (req.write)
			e.mask = '0;
		case (ofs)
		`RB_GPIO_OUT_OFS: begin
			e.rdata = riscboy_pkg::data_t'(out_m);
			if (req.write)
				out_m = req.wdata[`RB_N_PADS-1:0];
		end
		`RB_GPIO_OE_OFS: begin
			e.rdata = riscboy_pkg::data_t'(oe_m);
			if (req.write)
				oe_m = req.wdata[`RB_N_PADS-1:0];
		end
		`RB_GPIO_IN_OFS: begin
			e.rdata = riscboy_pkg::data_t'(padin);
			e.err   = req.write;             // IN is read only
		end
		default: begin
			e.err  = 1'b1;
			e.mask = '0;
		end
		endcase
	end
	return e;
endfunction

// ====================
// Comparison

task automatic flag(input string msg);
	errors++;
	$display("%0t ns: %s", $time, msg);
endtask

task automatic compare_rsp(input string name, input expect_t e, input riscboy_pkg::bus_rsp_t got);
	checks++;
	if (got.err !== e.err) begin
		errors++;
		$display("Fail %s.err: expected %h, got %h", name, e.err, got.err);
	end
	if ((got.rdata & e.mask) !== (e.rdata & e.mask)) begin
		errors++;
		$display("Fail %s.rdata: expected %h, got %h (mask %h)", name,
			e.rdata & e.mask, got.rdata & e.mask, e.mask);
	end
endtask

task automatic check_pads();
	checks++;
	if (padout !== out_m) begin
		errors++;
		$display("Fail padout: expected %h, got %h", out_m, padout);
	end
	if (padoe !== oe_m) begin
		errors++;
		$display("Fail padoe: expected %h, got %h", oe_m, padoe);
	end
endtask

always @(posedge clk) begin
	if (rst_n) begin
		if (ppu_req_valid && proc_req_ready)
			flag("proc request was granted while ppu was waiting");
		if ((proc_rsp_valid || ppu_rsp_valid) && (proc_req_ready || ppu_req_ready))
			flag("a request port was ready while a response was waiting");
		if (ppu_req_valid && ppu_req_ready)
			ppu_q.push_back(apply_request(ppu_req));
		if (proc_req_valid && proc_req_ready)
			proc_q.push_back(apply_request(proc_req));
		if (proc_rsp_valid && proc_rsp_ready) begin
			if (proc_q.size() == 0) begin
				flag("proc got a response it never asked for");
			end else begin
				compare_rsp("proc_rsp", proc_q.pop_front(), proc_rsp);
				check_pads();
			end
		end
		if (ppu_rsp_valid && ppu_rsp_ready) begin
			if (ppu_q.size() == 0) begin
				flag("ppu got a response it never asked for");
			end else begin
				compare_rsp("ppu_rsp", ppu_q.pop_front(), ppu_rsp);
				check_pads();
			end
		end
	end
end

endmodule

//--- hdl/riscboy_fabric.sv
/* Bus fabric top: arbiter, internal SRAM and the APB bridge to GPIO.
   Both masters are external to this block. */

`timescale 1ns/1ps

module riscboy_fabric (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  proc_req_valid,
	input  logic                  ppu_req_valid,
	input  riscboy_pkg::bus_req_t proc_req,
	input  riscboy_pkg::bus_req_t ppu_req,
	output logic                  proc_req_ready,
	output logic                  ppu_req_ready,
	output logic                  proc_rsp_valid,
	output logic                  ppu_rsp_valid,
	output riscboy_pkg::bus_rsp_t proc_rsp,
	output riscboy_pkg::bus_rsp_t ppu_rsp,
	input  logic                  proc_rsp_ready,
	input  logic                  ppu_rsp_ready,
	output riscboy_pkg::pads_t    padout,
	output riscboy_pkg::pads_t    padoe,
	input  riscboy_pkg::pads_t    padin
);

// ====================
// Interconnect

logic                  sram_valid;
logic                  sram_ready;
logic                  sram_rsp_valid;
riscboy_pkg::bus_rsp_t sram_rsp;
logic                  bridge_valid;
logic                  bridge_ready;
logic                  bridge_rsp_valid;
riscboy_pkg::bus_rsp_t bridge_rsp;
riscboy_pkg::bus_req_t tgt_req;      // Shared by both targets
riscboy_pkg::apb_req_t gpio_apb_req;
riscboy_pkg::apb_rsp_t gpio_apb_rsp;

bus_arbiter inst_bus_arbiter (
	.clk              (clk),
	.rst_n            (rst_n),
	.proc_req_valid   (proc_req_valid),
	.ppu_req_valid    (ppu_req_valid),
	.proc_req         (proc_req),
	.ppu_req          (ppu_req),
	.proc_req_ready   (proc_req_ready),
	.ppu_req_ready    (ppu_req_ready),
	.proc_rsp_valid   (proc_rsp_valid),
	.ppu_rsp_valid    (ppu_rsp_valid),
	.proc_rsp         (proc_rsp),
	.ppu_rsp          (ppu_rsp),
	.proc_rsp_ready   (proc_rsp_ready),
	.ppu_rsp_ready    (ppu_rsp_ready),
	.sram_valid       (sram_valid),
	.bridge_valid     (bridge_valid),
	.tgt_req          (tgt_req),
	.sram_ready       (sram_ready),
	.bridge_ready     (bridge_ready),
	.sram_rsp_valid   (sram_rsp_valid),
	.bridge_rsp_valid (bridge_rsp_valid),
	.sram_rsp         (sram_rsp),
	.bridge_rsp       (bridge_rsp)
);

sram_slave inst_sram (
	.clk       (clk),
	.rst_n     (rst_n),
	.tgt_valid (sram_valid),
	.tgt_req   (tgt_req),
	.tgt_ready (sram_ready),
	.rsp_valid (sram_rsp_valid),
	.rsp       (sram_rsp)
);

apb_bridge inst_apb_bridge (
	.clk       (clk),
	.rst_n     (rst_n),
	.tgt_valid (bridge_valid),
	.tgt_req   (tgt_req),
	.tgt_ready (bridge_ready),
	.rsp_valid (bridge_rsp_valid),
	.rsp       (bridge_rsp),
	.apb_req   (gpio_apb_req),
	.apb_rsp   (gpio_apb_rsp)
);

gpio_regs inst_gpio (
	.clk     (clk),
	.rst_n   (rst_n),
	.apb_req (gpio_apb_req),
	.apb_rsp (gpio_apb_rsp),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

endmodule

//--- hdl/gpio_regs.sv
/* GPIO with OUT, OE and IN registers, 25 pads, no pad multiplexing.
   padin goes through two flops, so a change takes two cycles to be readable.
   Always answers in the first access cycle. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module gpio_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  riscboy_pkg::apb_req_t apb_req,
	output riscboy_pkg::apb_rsp_t apb_rsp,
	output riscboy_pkg::pads_t    padout,
	output riscboy_pkg::pads_t    padoe,
	input  riscboy_pkg::pads_t    padin
);

riscboy_pkg::pads_t   out_q;
riscboy_pkg::pads_t   oe_q;
riscboy_pkg::pads_t   in_meta;
riscboy_pkg::pads_t   in_sync;
riscboy_pkg::paddr_t  ofs;
riscboy_pkg::data_t   prdata;
logic                 access;
logic                 bad_ofs;
logic                 ro_write;

assign ofs      = apb_req.paddr & ~`RB_APB_SLOT_MASK;
assign access   = apb_req.psel && apb_req.penable;
assign ro_write = apb_req.pwrite && ofs == `RB_GPIO_IN_OFS;

always_comb begin
	prdata  = '0;
	bad_ofs = 1'b0;
	case (ofs)
	`RB_GPIO_OUT_OFS: prdata = riscboy_pkg::data_t'(out_q);
	`RB_GPIO_OE_OFS:  prdata = riscboy_pkg::data_t'(oe_q);
	`RB_GPIO_IN_OFS:  prdata = riscboy_pkg::data_t'(in_sync);
	default:          bad_ofs = 1'b1;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		out_q <= '0;
		oe_q  <= '0;
	end else if (access && apb_req.pwrite) begin
		if (ofs == `RB_GPIO_OUT_OFS)
			out_q <= apb_req.pwdata[`RB_N_PADS-1:0];  // Upper bits dropped
		if (ofs == `RB_GPIO_OE_OFS)
			oe_q <= apb_req.pwdata[`RB_N_PADS-1:0];
	end
end

// Input synchronizer
always_ff @(posedge clk) begin
	in_meta <= padin;
	in_sync <= in_meta;
end

assign apb_rsp.prdata  = prdata;
assign apb_rsp.pready  = 1'b1;
assign apb_rsp.pslverr = access && (bad_ofs || ro_write);

assign padout = out_q;
assign padoe  = oe_q;

endmodule

//--- hdl/apb_bridge.sv
/* Target port to APB master. Only the GPIO slot is mapped; other slots
   get an error with no bus cycle. APB writes are whole words, so wstrb
   is not carried onto the peripheral bus. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module apb_bridge (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tgt_valid,
	input  riscboy_pkg::bus_req_t tgt_req,
	output logic                  tgt_ready,
	output logic                  rsp_valid,
	output riscboy_pkg::bus_rsp_t rsp,
	output riscboy_pkg::apb_req_t apb_req,
	input  riscboy_pkg::apb_rsp_t apb_rsp
);

riscboy_pkg::apb_state_e state;
riscboy_pkg::paddr_t     paddr_in;
riscboy_pkg::paddr_t     paddr_q;
riscboy_pkg::data_t      pwdata_q;
logic                    pwrite_q;
logic                    slot_hit;
riscboy_pkg::bus_rsp_t   rsp_q;

assign paddr_in  = tgt_req.addr[`RB_W_PADDR-1:0];
assign slot_hit  = (paddr_in & `RB_APB_SLOT_MASK) == `RB_GPIO_SLOT;
assign tgt_ready = state == riscboy_pkg::APB_IDLE;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state     <= riscboy_pkg::APB_IDLE;
		rsp_valid <= 1'b0;
	end else begin
		rsp_valid <= 1'b0;
		case (state)
		riscboy_pkg::APB_IDLE: begin
			if (tgt_valid) begin
				if (slot_hit)
					state <= riscboy_pkg::APB_SETUP;
				else
					rsp_valid <= 1'b1;  // Unmapped slot
			end
		end
		riscboy_pkg::APB_SETUP: state <= riscboy_pkg::APB_ACCESS;
		riscboy_pkg::APB_ACCESS: begin
			if (apb_rsp.pready) begin
				state     <= riscboy_pkg::APB_IDLE;
				rsp_valid <= 1'b1;
			end
		end
		default: state <= riscboy_pkg::APB_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == riscboy_pkg::APB_IDLE && tgt_valid) begin
		paddr_q     <= paddr_in;
		pwrite_q    <= tgt_req.write;
		pwdata_q    <= tgt_req.wdata;
		rsp_q.rdata <= '0;     // Error unless the access completes
		rsp_q.err   <= 1'b1;
	end else if (state == riscboy_pkg::APB_ACCESS && apb_rsp.pready) begin
		rsp_q.rdata <= apb_rsp.prdata;
		rsp_q.err   <= apb_rsp.pslverr;
	end
end

assign rsp = rsp_q;

assign apb_req.paddr   = paddr_q;
assign apb_req.psel    = state != riscboy_pkg::APB_IDLE;
assign apb_req.penable = state == riscboy_pkg::APB_ACCESS;
assign apb_req.pwrite  = pwrite_q;
assign apb_req.pwdata  = pwdata_q;

// ====================
// APB protocol

a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
	$rose(apb_req.penable) |-> $past(apb_req.psel) && !$past(apb_req.penable))
	else $error("penable without a setup phase");

a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
	apb_req.penable |-> $stable(apb_req.paddr) && $stable(apb_req.pwrite))
	else $error("paddr changed during access");

endmodule

//--- hdl/sram_slave.sv
/* Single-port synchronous SRAM, 2K words, no preload.
   Always ready; a write response carries the word as it was before the write. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module sram_slave (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tgt_valid,
	input  riscboy_pkg::bus_req_t tgt_req,
	output logic                  tgt_ready,
	output logic                  rsp_valid,
	output riscboy_pkg::bus_rsp_t rsp
);

riscboy_pkg::data_t              mem [0:(1 << `RB_SRAM_DEPTH_LOG2)-1];
riscboy_pkg::data_t              rdata_q;
logic [`RB_SRAM_DEPTH_LOG2-1:0] widx;

assign tgt_ready = 1'b1;
assign widx      = tgt_req.addr[`RB_SRAM_DEPTH_LOG2+1:2]; // Word address

always_ff @(posedge clk) begin
	if (tgt_valid) begin
		if (tgt_req.write) begin
			for (int i = 0; i < `RB_W_DATA / 8; i++) begin
				if (tgt_req.wstrb[i])
					mem[widx][i*8 +: 8] <= tgt_req.wdata[i*8 +: 8];
			end
		end
		rdata_q <= mem[widx];
	end
end

always_ff @(posedge clk) begin
	if (!rst_n)
		rsp_valid <= 1'b0;
	else
		rsp_valid <= tgt_valid && tgt_ready; // One cycle after acceptance
end

assign rsp.rdata = rdata_q;
assign rsp.err   = 1'b0;

endmodule

//--- hdl/bus_arbiter.sv
/* Two-master arbiter with one transaction in flight. ppu has fixed priority,
   so a busy ppu can starve proc. Addresses outside both windows get an error
   response without touching a target. */

`timescale 1ns/1ps
`include "riscboy_macros.svh"

module bus_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  proc_req_valid,
	input  logic                  ppu_req_valid,
	input  riscboy_pkg::bus_req_t proc_req,
	input  riscboy_pkg::bus_req_t ppu_req,
	output logic                  proc_req_ready,
	output logic                  ppu_req_ready,
	output logic                  proc_rsp_valid,
	output logic                  ppu_rsp_valid,
	output riscboy_pkg::bus_rsp_t proc_rsp,
	output riscboy_pkg::bus_rsp_t ppu_rsp,
	input  logic                  proc_rsp_ready,
	input  logic                  ppu_rsp_ready,
	output logic                  sram_valid,
	output logic                  bridge_valid,
	output riscboy_pkg::bus_req_t tgt_req,
	input  logic                  sram_ready,
	input  logic                  bridge_ready,
	input  logic                  sram_rsp_valid,
	input  logic                  bridge_rsp_valid,
	input  riscboy_pkg::bus_rsp_t sram_rsp,
	input  riscboy_pkg::bus_rsp_t bridge_rsp
);

riscboy_pkg::arb_state_e state;
logic                    owner_ppu;
logic                    sel_sram;
logic                    sel_bridge;
logic                    issued;    // Target has taken the request
riscboy_pkg::bus_req_t   req_q;
riscboy_pkg::bus_rsp_t   rsp_q;

riscboy_pkg::bus_req_t   req_in;
riscboy_pkg::bus_rsp_t   tgt_rsp;
logic                    accept;
logic                    hit_sram;
logic                    hit_apb;
logic                    miss;
logic                    tgt_rsp_valid;
logic                    rsp_accept;

// ====================
// Grant and decode

assign ppu_req_ready  = state == riscboy_pkg::ARB_IDLE;
assign proc_req_ready = state == riscboy_pkg::ARB_IDLE && !ppu_req_valid; // ppu wins ties
assign accept = (ppu_req_valid && ppu_req_ready) || (proc_req_valid && proc_req_ready);
assign req_in = ppu_req_valid ? ppu_req : proc_req;

assign hit_sram = (req_in.addr & `RB_SRAM_MASK) == `RB_SRAM_BASE;
assign hit_apb  = (req_in.addr & `RB_APB_MASK) == `RB_APB_BASE;
assign miss     = !(sel_sram || sel_bridge);

// ====================
// Target side

assign sram_valid   = state == riscboy_pkg::ARB_BUSY && sel_sram && !issued;
assign bridge_valid = state == riscboy_pkg::ARB_BUSY && sel_bridge && !issued;
assign tgt_req      = req_q;

assign tgt_rsp_valid = sram_rsp_valid || bridge_rsp_valid;
assign tgt_rsp       = sram_rsp_valid ? sram_rsp : bridge_rsp;

// Response goes back only to the owner
assign proc_rsp_valid = state == riscboy_pkg::ARB_RESPOND && !owner_ppu;
assign ppu_rsp_valid  = state == riscboy_pkg::ARB_RESPOND && owner_ppu;
assign proc_rsp       = rsp_q;
assign ppu_rsp        = rsp_q;
assign rsp_accept     = (proc_rsp_valid && proc_rsp_ready) || (ppu_rsp_valid && ppu_rsp_ready);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state      <= riscboy_pkg::ARB_IDLE;
		owner_ppu  <= 1'b0;
		sel_sram   <= 1'b0;
		sel_bridge <= 1'b0;
		issued     <= 1'b0;
	end else begin
		case (state)
		riscboy_pkg::ARB_IDLE: begin
			if (accept) begin
				state      <= riscboy_pkg::ARB_BUSY;
				owner_ppu  <= ppu_req_valid;
				sel_sram   <= hit_sram;
				sel_bridge <= hit_apb;
				issued     <= 1'b0;
			end
		end
		riscboy_pkg::ARB_BUSY: begin
			if ((sram_valid && sram_ready) || (bridge_valid && bridge_ready))
				issued <= 1'b1;
			if (tgt_rsp_valid || miss)
				state <= riscboy_pkg::ARB_RESPOND;
		end
		riscboy_pkg::ARB_RESPOND: begin
			if (rsp_accept)
				state <= riscboy_pkg::ARB_IDLE;
		end
		default: state <= riscboy_pkg::ARB_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (accept)
		req_q <= req_in;
	if (state == riscboy_pkg::ARB_BUSY) begin
		if (tgt_rsp_valid) begin
			rsp_q <= tgt_rsp;
		end else if (miss) begin
			rsp_q.rdata <= '0;   // Decode error
			rsp_q.err   <= 1'b1;
		end
	end
end

// ====================
// Checks

a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
	!(sram_valid && bridge_valid))
	else $error("arbiter drives both targets at once");

a_owner_stable: assert property (@(posedge clk) disable iff (!rst_n)
	state != riscboy_pkg::ARB_IDLE |=> state == riscboy_pkg::ARB_IDLE || $stable(owner_ppu))
	else $error("owner changed during a transaction");

a_proc_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
	proc_rsp_valid && !proc_rsp_ready |=> proc_rsp_valid && $stable(proc_rsp))
	else $error("proc response dropped before ready");

a_ppu_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
	ppu_rsp_valid && !ppu_rsp_ready |=> ppu_rsp_valid && $stable(ppu_rsp))
	else $error("ppu response dropped before ready");

endmodule

//--- hdl/riscboy_pkg.sv
/* Shared types of the fabric. Widths come from the macro header.
   State encodings are local to each FSM and not visible on any port. */

`include "riscboy_macros.svh"

package riscboy_pkg;

	typedef logic [`RB_W_ADDR-1:0]   addr_t;
	typedef logic [`RB_W_DATA-1:0]   data_t;
	typedef logic [`RB_W_DATA/8-1:0] strb_t;
	typedef logic [`RB_W_PADDR-1:0]  paddr_t;
	typedef logic [`RB_N_PADS-1:0]   pads_t;

	// Request from a master, or toward a target
	typedef struct packed {
		addr_t addr;
		logic  write;
		data_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		data_t rdata;
		logic  err;    // Decode or slave error
	} bus_rsp_t;

	typedef struct packed {
		paddr_t paddr;
		logic   psel;
		logic   penable;
		logic   pwrite;
		data_t  pwdata;
	} apb_req_t;

	typedef struct packed {
		data_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_BUSY, ARB_RESPOND} arb_state_e;
	typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_e;

endpackage

//--- hdl/riscboy_macros.svh
/* Fixed widths and address map of the bus fabric.
   SRAM decode ignores address bits other than the top three and bit 19,
   so the 8 KiB array aliases through its window. */

`ifndef RISCBOY_MACROS_SVH
`define RISCBOY_MACROS_SVH

// ====================
// Bus widths
`define RB_W_ADDR          32
`define RB_W_DATA          32
`define RB_W_PADDR         16

// ====================
// System address map
`define RB_SRAM_BASE       32'h2000_0000
`define RB_SRAM_MASK       32'he008_0000
`define RB_SRAM_DEPTH_LOG2 11            // 2K words
`define RB_APB_BASE        32'h4000_0000
`define RB_APB_MASK        32'he000_0000

// ====================
// Peripheral map
`define RB_APB_SLOT_MASK   16'hf000
`define RB_GPIO_SLOT       16'h0000
`define RB_GPIO_OUT_OFS    16'h0000
`define RB_GPIO_OE_OFS     16'h0004
`define RB_GPIO_IN_OFS     16'h0008
`define RB_N_PADS          25

`endif
